//--- nts_dispatch_cfg.svh
// NTS dispatcher configuration
// Buffer depth, engine count and MAC lane width shared by all stages

`ifndef NTS_DISPATCH_CFG_SVH
`define NTS_DISPATCH_CFG_SVH

// Word address width of one ping-pong bank
`define NTS_ADDR_WIDTH 8

// Number of processing engines behind the dispatcher
`define NTS_ENGINES 4

// Bytes per MAC receive word
`define NTS_LANES 8

`endif

//--- nts_rx_pkg.sv
// NTS receive-side types
// MAC word, byte-valid mask and last-word byte count

`include "nts_dispatch_cfg.svh"

package nts_rx_pkg;

  // One MAC receive word, also the buffer word
  typedef logic [`NTS_LANES*8-1:0] mac_word_t;

  // One valid bit per byte lane
  typedef logic [`NTS_LANES-1:0] mac_mask_t;

  // Valid bytes in the last word, 0 to 8
  typedef logic [3:0] byte_count_t;

endpackage

//--- nts_buf_pkg.sv
// NTS packet buffer types
// Bank word address and the shared bank state encoding

`include "nts_dispatch_cfg.svh"

package nts_buf_pkg;

  // Word address inside one bank
  typedef logic [`NTS_ADDR_WIDTH-1:0] buf_addr_t;

  // ------------------------------------------------------------
  // Bank states
  // ------------------------------------------------------------
  // Writer side uses EMPTY to PACKET_RECEIVED and ERROR
  // Reader side uses EMPTY and the OUT states
  typedef enum logic [3:0] {
    EMPTY           = 4'd0,
    HAS_DATA        = 4'd1,
    PACKET_RECEIVED = 4'd2,
    OUT_INIT_0      = 4'd3,  // Announced, waiting for start
    OUT_INIT_1      = 4'd4,
    OUT             = 4'd5,
    OUT_FIN_0       = 4'd6,
    OUT_FIN_1       = 4'd7,  // Drained, waiting for discard
    ERROR           = 4'd8
  } bank_state_t;

endpackage

//--- nts_rx_frontend.sv
// NTS receive front end
// Start-of-frame detection, byte lane reversal and last-word byte count

`timescale 1ns/1ns

`include "nts_dispatch_cfg.svh"

module nts_rx_frontend
  import nts_rx_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_areset,
  input  mac_word_t   i_rx_data,
  input  mac_mask_t   i_rx_data_valid,
  output logic        o_sof,
  output mac_word_t   o_word,
  output byte_count_t o_bytes
);

  mac_mask_t prev_valid;

  // Idle ones so that reset never looks like a gap before a frame
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
      prev_valid <= '1;
    else
      prev_valid <= i_rx_data_valid;
  end

  // Empty mask followed by a full one
  assign o_sof = (prev_valid == '0) && (i_rx_data_valid == '1);

  // Lane k moves to lane LANES-1-k, invalid lanes cleared
  always_comb
  begin
    for (int k = 0; k < `NTS_LANES; k++)
    begin
      o_word[(`NTS_LANES-1-k)*8 +: 8] = i_rx_data_valid[k] ? i_rx_data[k*8 +: 8] : 8'h00;
    end
  end

  // Count only for low-aligned contiguous masks
  always_comb
  begin
    o_bytes = '0;
    for (int n = 0; n <= `NTS_LANES; n++)
    begin
      if (i_rx_data_valid == mac_mask_t'((1 << n) - 1))
        o_bytes = byte_count_t'(n);
    end
  end

endmodule

//--- nts_frame_writer.sv
// NTS frame writer
// Stores received frames in the write bank and hands full banks to the reader

`timescale 1ns/1ns

module nts_frame_writer
  import nts_rx_pkg::*, nts_buf_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_areset,
  input  logic        i_enable,
  input  logic        i_sof,
  input  mac_word_t   i_word,
  input  byte_count_t i_bytes,
  input  logic        i_rx_valid_any,
  input  logic        i_rx_good_frame,
  input  logic        i_rx_bad_frame,
  input  logic        i_reader_idle,
  output logic        o_wr_en,
  output buf_addr_t   o_wr_addr,
  output mac_word_t   o_wr_data,
  output logic        o_bank,
  output logic        o_frame_ready,
  output buf_addr_t   o_last_addr,
  output byte_count_t o_last_bytes
);

  bank_state_t state, state_nxt;
  buf_addr_t   count, count_nxt;     // Address of last stored word
  byte_count_t bytes, bytes_nxt;
  logic        wr_en_nxt;
  buf_addr_t   wr_addr_nxt;

  // ------------------------------------------------------------
  // Write side state machine
  // ------------------------------------------------------------
  always_comb
  begin
    state_nxt     = state;
    count_nxt     = count;
    bytes_nxt     = bytes;
    wr_en_nxt     = 1'b0;
    wr_addr_nxt   = '0;
    o_frame_ready = 1'b0;

    if (i_rx_bad_frame)
    begin
      state_nxt = EMPTY;
      count_nxt = '0;
      bytes_nxt = '0;
    end
    else
    begin
      case (state)
        EMPTY:
          if (i_sof && i_enable)
          begin
            state_nxt = HAS_DATA;
            count_nxt = '0;
            bytes_nxt = '0;
            wr_en_nxt = 1'b1;   // Word 0 at address 0
          end
        HAS_DATA:
          if (i_rx_valid_any && (count == '1))
            state_nxt = ERROR;  // Bank overrun
          else
          begin
            if (i_rx_valid_any)
            begin
              count_nxt   = count + 1'b1;
              wr_en_nxt   = 1'b1;
              wr_addr_nxt = count + 1'b1;
            end
            if (i_rx_good_frame)
            begin
              bytes_nxt = i_bytes;
              state_nxt = PACKET_RECEIVED;
            end
          end
        PACKET_RECEIVED:
          if (i_reader_idle)
          begin
            o_frame_ready = 1'b1;  // Bank flips at this edge
            state_nxt     = EMPTY;
          end
        default:
          state_nxt = EMPTY;
      endcase
    end
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      state   <= EMPTY;
      count   <= '0;
      bytes   <= '0;
      o_bank  <= 1'b0;
      o_wr_en <= 1'b0;
    end
    else
    begin
      state   <= state_nxt;
      count   <= count_nxt;
      bytes   <= bytes_nxt;
      o_bank  <= o_bank ^ o_frame_ready;
      o_wr_en <= wr_en_nxt;
    end
  end

  // Write payload follows the input word by one cycle
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      o_wr_addr <= '0;
      o_wr_data <= '0;
    end
    else
    begin
      o_wr_addr <= wr_addr_nxt;
      o_wr_data <= i_word;
    end
  end

  assign o_last_addr  = count;
  assign o_last_bytes = bytes;

endmodule

//--- nts_packet_buffer.sv
// NTS packet buffer
// Two single-port RAM banks, one written by the receiver, one read out

`timescale 1ns/1ns

module nts_packet_buffer
  import nts_buf_pkg::*, nts_rx_pkg::mac_word_t;
(
  input  logic      i_clk,
  input  logic      i_bank,     // Bank being written
  input  logic      i_wr_en,
  input  buf_addr_t i_wr_addr,
  input  mac_word_t i_wr_data,
  input  buf_addr_t i_rd_addr,
  output mac_word_t o_rd_data
);

  localparam int DEPTH = 2 ** $bits(buf_addr_t);

  mac_word_t rd_data [2];

  // ------------------------------------------------------------
  // Banks
  // ------------------------------------------------------------
  for (genvar b = 0; b < 2; b++)
  begin : g_bank
    mac_word_t ram [DEPTH];
    logic      we;
    buf_addr_t addr;

    // Write bank takes the write address only while writing
    assign we   = i_wr_en && (i_bank == 1'(b));
    assign addr = we ? i_wr_addr : i_rd_addr;

    always_ff @(posedge i_clk)
    begin
      if (we)
        ram[addr] <= i_wr_data;
      rd_data[b] <= ram[addr];  // Registered read
    end
  end

  // Reader owns the bank not being written
  assign o_rd_data = rd_data[~i_bank];

endmodule

//--- nts_fifo_reader.sv
// NTS FIFO reader
// Announces a handed-over frame and bursts it out one word per cycle

`timescale 1ns/1ns

module nts_fifo_reader
  import nts_rx_pkg::*, nts_buf_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_areset,
  input  logic        i_frame_ready,
  input  buf_addr_t   i_last_addr,
  input  byte_count_t i_last_bytes,
  input  logic        i_rd_start,
  input  logic        i_discard,
  input  mac_word_t   i_rd_data,
  output buf_addr_t   o_rd_addr,
  output logic        o_reader_idle,
  output logic        o_packet_available,
  output byte_count_t o_last_bytes,
  output logic        o_fifo_empty,
  output logic        o_fifo_rd_valid,
  output mac_word_t   o_fifo_rd_data
);

  bank_state_t state, state_nxt;
  buf_addr_t   last_addr;
  buf_addr_t   rd_addr_nxt;
  logic        empty_nxt;
  logic        valid_nxt;

  // ------------------------------------------------------------
  // Read side state machine
  // ------------------------------------------------------------
  always_comb
  begin
    state_nxt   = state;
    rd_addr_nxt = '0;
    empty_nxt   = o_fifo_empty;
    valid_nxt   = 1'b0;

    if (i_frame_ready)
      state_nxt = OUT_INIT_0;
    else if (i_discard)
    begin
      state_nxt = EMPTY;
      empty_nxt = 1'b1;
    end
    else
    begin
      case (state)
        OUT_INIT_0:
        begin
          empty_nxt = 1'b0;
          if (i_rd_start)
            state_nxt = OUT_INIT_1;
        end
        OUT_INIT_1:
        begin
          rd_addr_nxt = buf_addr_t'(1);
          // Single word frame skips the burst
          state_nxt   = (last_addr == '0) ? OUT_FIN_0 : OUT;
        end
        OUT:
        begin
          valid_nxt = 1'b1;
          if (o_rd_addr == last_addr)
          begin
            state_nxt   = OUT_FIN_0;
            rd_addr_nxt = o_rd_addr;
          end
          else
            rd_addr_nxt = o_rd_addr + 1'b1;
        end
        OUT_FIN_0:
        begin
          valid_nxt = 1'b1;         // Last word
          state_nxt = OUT_FIN_1;
        end
        OUT_FIN_1:
          empty_nxt = 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      state           <= EMPTY;
      o_rd_addr       <= '0;
      last_addr       <= '0;
      o_last_bytes    <= '0;
      o_fifo_empty    <= 1'b0;
      o_fifo_rd_valid <= 1'b0;
      o_fifo_rd_data  <= '0;
    end
    else
    begin
      state           <= state_nxt;
      o_rd_addr       <= rd_addr_nxt;
      o_fifo_empty    <= empty_nxt;
      o_fifo_rd_valid <= valid_nxt;
      o_fifo_rd_data  <= valid_nxt ? i_rd_data : '0;
      if (i_frame_ready)
      begin
        last_addr    <= i_last_addr;
        o_last_bytes <= i_last_bytes;
      end
    end
  end

  assign o_reader_idle      = (state == EMPTY);
  assign o_packet_available = (state == OUT_INIT_0);

endmodule

//--- nts_engine_select.sv
// NTS engine select
// Round-robin search for a free engine and routing of the reader to it

`timescale 1ns/1ns

`include "nts_dispatch_cfg.svh"

module nts_engine_select
  import nts_rx_pkg::*;
#(
  parameter int ENGINES = `NTS_ENGINES
) (
  input  logic                      i_clk,
  input  logic                      i_areset,
  input  logic        [ENGINES-1:0] i_busy,
  input  logic        [ENGINES-1:0] i_read_discard,
  input  logic        [ENGINES-1:0] i_rd_start,
  input  logic                      i_packet_available,
  input  byte_count_t               i_last_bytes,
  input  logic                      i_fifo_empty,
  input  logic                      i_rd_valid,
  input  mac_word_t                 i_rd_data,
  output logic        [ENGINES-1:0] o_packet_available,
  output byte_count_t [ENGINES-1:0] o_data_valid,
  output logic        [ENGINES-1:0] o_fifo_empty,
  output logic        [ENGINES-1:0] o_rd_valid,
  output mac_word_t   [ENGINES-1:0] o_rd_data,
  output logic                      o_rd_start,
  output logic                      o_discard
);

  localparam int IDX_W = (ENGINES > 1) ? $clog2(ENGINES) : 1;
  localparam int CNT_W = $clog2(4 * ENGINES);

  typedef enum logic {SEARCH, HOLD} mode_t;

  mode_t            mode, mode_nxt;
  logic [IDX_W-1:0] index, index_nxt;
  logic [CNT_W-1:0] search_cnt, search_cnt_nxt;
  logic             forward;

  always_comb
  begin
    mode_nxt           = mode;
    index_nxt          = index;
    search_cnt_nxt     = search_cnt;
    forward            = 1'b0;
    o_rd_start         = 1'b0;
    o_discard          = 1'b0;
    o_packet_available = '0;
    o_data_valid       = '0;
    o_fifo_empty       = '0;
    o_rd_valid         = '0;
    o_rd_data          = '0;

    case (mode)
      HOLD:
      begin
        // Only the held engine sees the reader
        o_rd_start                = i_rd_start[index];
        o_discard                 = i_read_discard[index];
        o_packet_available[index] = i_packet_available;
        o_data_valid[index]       = i_last_bytes;
        o_fifo_empty[index]       = i_fifo_empty;
        o_rd_valid[index]         = i_rd_valid;
        o_rd_data[index]          = i_rd_data;
        if (i_read_discard[index])
        begin
          forward  = 1'b1;
          mode_nxt = SEARCH;
        end
      end
      default:
        if (i_busy[index])
          forward = 1'b1;   // Skip busy engine
        else
          mode_nxt = HOLD;
    endcase

    // ------------------------------------------------------------
    // Step to the next engine
    // ------------------------------------------------------------
    if (forward)
    begin
      index_nxt      = (index == IDX_W'(ENGINES - 1)) ? '0 : index + 1'b1;
      search_cnt_nxt = (search_cnt == CNT_W'(4*ENGINES - 1)) ? '0 : search_cnt + 1'b1;
      if (search_cnt == '0)
        o_discard = 1'b1;   // Flush a packet nobody took
    end
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      mode       <= SEARCH;
      index      <= '0;
      search_cnt <= CNT_W'(1);
    end
    else
    begin
      mode       <= mode_nxt;
      index      <= index_nxt;
      search_cnt <= search_cnt_nxt;
    end
  end

endmodule

//--- nts_dispatcher.sv
// NTS dispatcher top level
// MAC receive path into ping-pong buffers, read out to one free engine

`timescale 1ns/1ns

`include "nts_dispatch_cfg.svh"

module nts_dispatcher
  import nts_rx_pkg::*, nts_buf_pkg::*;
(
  input  logic                           i_clk,
  input  logic                           i_areset,
  input  logic                           i_enable,
  input  mac_word_t                      i_rx_data,
  input  mac_mask_t                      i_rx_data_valid,
  input  logic                           i_rx_good_frame,
  input  logic                           i_rx_bad_frame,
  input  logic [`NTS_ENGINES-1:0]        i_dispatch_busy,
  input  logic [`NTS_ENGINES-1:0]        i_dispatch_packet_read_discard,
  input  logic [`NTS_ENGINES-1:0]        i_dispatch_fifo_rd_start,
  output logic [`NTS_ENGINES-1:0]        o_dispatch_packet_available,
  output logic [`NTS_ENGINES*4-1:0]      o_dispatch_data_valid,
  output logic [`NTS_ENGINES-1:0]        o_dispatch_fifo_empty,
  output logic [`NTS_ENGINES-1:0]        o_dispatch_fifo_rd_valid,
  output logic [`NTS_ENGINES*`NTS_LANES*8-1:0] o_dispatch_fifo_rd_data
);

  // Front end to writer
  logic        sof;
  mac_word_t   word;
  byte_count_t bytes;
  logic        rx_valid_any;

  // Writer to buffer and reader
  logic        wr_en;
  buf_addr_t   wr_addr;
  mac_word_t   wr_data;
  logic        bank;
  logic        frame_ready;
  buf_addr_t   last_addr;
  byte_count_t last_bytes;

  // Reader side
  logic        reader_idle;
  buf_addr_t   rd_addr;
  mac_word_t   rd_data;
  logic        packet_available;
  byte_count_t rd_last_bytes;
  logic        fifo_empty;
  logic        fifo_rd_valid;
  mac_word_t   fifo_rd_data;
  logic        sel_rd_start;
  logic        sel_discard;

  assign rx_valid_any = |i_rx_data_valid;

  // ------------------------------------------------------------
  // Receive path
  // ------------------------------------------------------------
  nts_rx_frontend nts_rx_frontend_i (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_rx_data       (i_rx_data),
    .i_rx_data_valid (i_rx_data_valid),
    .o_sof           (sof),
    .o_word          (word),
    .o_bytes         (bytes)
  );

  nts_frame_writer nts_frame_writer_i (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_enable        (i_enable),
    .i_sof           (sof),
    .i_word          (word),
    .i_bytes         (bytes),
    .i_rx_valid_any  (rx_valid_any),
    .i_rx_good_frame (i_rx_good_frame),
    .i_rx_bad_frame  (i_rx_bad_frame),
    .i_reader_idle   (reader_idle),
    .o_wr_en         (wr_en),
    .o_wr_addr       (wr_addr),
    .o_wr_data       (wr_data),
    .o_bank          (bank),
    .o_frame_ready   (frame_ready),
    .o_last_addr     (last_addr),
    .o_last_bytes    (last_bytes)
  );

  nts_packet_buffer nts_packet_buffer_i (
    .i_clk     (i_clk),
    .i_bank    (bank),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  // ------------------------------------------------------------
  // Read-out and engine dispatch
  // ------------------------------------------------------------
  nts_fifo_reader nts_fifo_reader_i (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_frame_ready      (frame_ready),
    .i_last_addr        (last_addr),
    .i_last_bytes       (last_bytes),
    .i_rd_start         (sel_rd_start),
    .i_discard          (sel_discard),
    .i_rd_data          (rd_data),
    .o_rd_addr          (rd_addr),
    .o_reader_idle      (reader_idle),
    .o_packet_available (packet_available),
    .o_last_bytes       (rd_last_bytes),
    .o_fifo_empty       (fifo_empty),
    .o_fifo_rd_valid    (fifo_rd_valid),
    .o_fifo_rd_data     (fifo_rd_data)
  );

  nts_engine_select #(
    .ENGINES (`NTS_ENGINES)
  ) nts_engine_select_i (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_busy             (i_dispatch_busy),
    .i_read_discard     (i_dispatch_packet_read_discard),
    .i_rd_start         (i_dispatch_fifo_rd_start),
    .i_packet_available (packet_available),
    .i_last_bytes       (rd_last_bytes),
    .i_fifo_empty       (fifo_empty),
    .i_rd_valid         (fifo_rd_valid),
    .i_rd_data          (fifo_rd_data),
    .o_packet_available (o_dispatch_packet_available),
    .o_data_valid       (o_dispatch_data_valid),
    .o_fifo_empty       (o_dispatch_fifo_empty),
    .o_rd_valid         (o_dispatch_fifo_rd_valid),
    .o_rd_data          (o_dispatch_fifo_rd_data),
    .o_rd_start         (sel_rd_start),
    .o_discard          (sel_discard)
  );

endmodule

//--- tb_nts_dispatcher.sv
// NTS dispatcher testbench
// Random MAC frames through the dispatcher, checked against a byte-reversal model

`timescale 1ns/1ns

`include "nts_dispatch_cfg.svh"

module tb_nts_dispatcher
  import nts_rx_pkg::*;
();

  localparam int ENGINES      = `NTS_ENGINES;
  localparam int WORD_W       = `NTS_LANES * 8;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int MAX_WORDS    = 12;
  localparam int FRAMES       = 12;   // Frames sent over the whole run
  localparam int WAIT_LIMIT   = 60;
  localparam int RUN_CYCLES   = RESET_CYCLES + FRAMES * (3 * MAX_WORDS + 2 * WAIT_LIMIT);

  logic                    clk = 1'b0;
  logic                    areset;
  logic                    enable;
  mac_word_t               rx_data;
  mac_mask_t               rx_valid;
  logic                    rx_good;
  logic                    rx_bad;
  logic [ENGINES-1:0]      busy;
  logic [ENGINES-1:0]      discard;
  logic [ENGINES-1:0]      rd_start;
  logic [ENGINES-1:0]      avail;
  logic [ENGINES*4-1:0]    data_valid;
  logic [ENGINES-1:0]      fifo_empty;
  logic [ENGINES-1:0]      rd_valid;
  logic [ENGINES*WORD_W-1:0] rd_data;

  // Reference model state
  mac_word_t exp_words [$];   // Reversed words of every stored frame, in order
  int        exp_lengths [$];
  int        exp_counts [$];
  int        cur_engine;      // Engine the dispatcher should hold
  bit        empty_armed;     // Held engine's FIFO empty must stay up
  int        errors, checks, tests_run, tests_failed, test_base;

  always #(CLK_PERIOD / 2) clk = ~clk;

  nts_dispatcher nts_dispatcher_i (
    .i_clk                          (clk),
    .i_areset                       (areset),
    .i_enable                       (enable),
    .i_rx_data                      (rx_data),
    .i_rx_data_valid                (rx_valid),
    .i_rx_good_frame                (rx_good),
    .i_rx_bad_frame                 (rx_bad),
    .i_dispatch_busy                (busy),
    .i_dispatch_packet_read_discard (discard),
    .i_dispatch_fifo_rd_start       (rd_start),
    .o_dispatch_packet_available    (avail),
    .o_dispatch_data_valid          (data_valid),
    .o_dispatch_fifo_empty          (fifo_empty),
    .o_dispatch_fifo_rd_valid       (rd_valid),
    .o_dispatch_fifo_rd_data        (rd_data)
  );

  // Input lane 0 ends up on top after all shifts
  function automatic mac_word_t reverse_lanes(input mac_word_t data, input mac_mask_t mask);
    mac_word_t res;
    res = '0;
    for (int k = 0; k < `NTS_LANES; k++)
      res = {res[WORD_W-9:0], mask[k] ? data[k*8 +: 8] : 8'h00};
    return res;
  endfunction

  function automatic int next_free(input int from, input logic [ENGINES-1:0] busy_mask);
    int idx;
    idx = from;
    for (int n = 0; n < ENGINES; n++)
    begin
      idx = (idx + 1) % ENGINES;
      if (!busy_mask[idx])
        return idx;
    end
    return from;
  endfunction

  task automatic report_problem(input string what);
    $display("Error at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic check_hex(input string sig, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("Fail %s got %h expected %h", sig, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_base)
      $display("Test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, errors - test_base);
    end
    test_base = errors;
  endtask

  // ------------------------------------------------------------
  // Frame stimulus
  // ------------------------------------------------------------
  task automatic send_frame(input int nwords, input int last_n, input bit bad, input bit store);
    mac_word_t data;
    mac_mask_t mask;
    logic      last;
    for (int w = 0; w < nwords; w++)
    begin
      last = (w == nwords - 1);
      data = {$urandom, $urandom};
      mask = last ? mac_mask_t'((1 << last_n) - 1) : '1;
      @(negedge clk);
      rx_data  = data;
      rx_valid = mask;
      rx_good  = last && !bad;   // Strobe rides on the last word
      rx_bad   = last && bad;
      if (store)
        exp_words.push_back(reverse_lanes(data, mask));
    end
    @(negedge clk);
    rx_data  = '0;
    rx_valid = '0;   // Gap so the next frame sees a start
    rx_good  = 1'b0;
    rx_bad   = 1'b0;
    if (store)
    begin
      exp_lengths.push_back(nwords);
      exp_counts.push_back($countones(mask));
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles)
    begin
      @(negedge clk);
      check_hex("o_dispatch_packet_available", avail, 0);
    end
  endtask

  // Wait for the announce on the held engine, burst the frame out, discard it
  task automatic read_frame();
    int        nwords;
    int        nbytes;
    int        cnt;
    int        eng;
    mac_word_t expected;
    eng    = cur_engine;
    nwords = exp_lengths.pop_front();
    nbytes = exp_counts.pop_front();
    cnt    = 0;
    while (!avail[eng] && cnt < WAIT_LIMIT)
    begin
      @(negedge clk);
      cnt++;
    end
    empty_armed = 1'b0;
    assert (avail[eng])
    else report_problem($sformatf("no frame announced to engine %0d", eng));
    if (!avail[eng])
    begin
      repeat (nwords) expected = exp_words.pop_front();
      return;
    end
    check_hex("o_dispatch_packet_available", avail, 64'(1) << eng);
    check_hex("o_dispatch_data_valid", data_valid[eng*4 +: 4], nbytes);
    rd_start[eng] = 1'b1;
    @(negedge clk);
    rd_start = '0;
    cnt      = 1;
    while (!rd_valid[eng] && cnt < WAIT_LIMIT)
    begin
      @(negedge clk);
      cnt++;
    end
    assert (cnt == 3)
    else report_problem($sformatf("first word came %0d cycles after start, not 3", cnt));
    for (int w = 0; w < nwords; w++)
    begin
      expected = exp_words.pop_front();
      check_hex("o_dispatch_fifo_rd_valid", rd_valid, 64'(1) << eng);
      check_hex("o_dispatch_fifo_rd_data", rd_data[eng*WORD_W +: WORD_W], expected);
      @(negedge clk);
    end
    check_hex("o_dispatch_fifo_rd_valid", rd_valid, 0);   // Burst is exactly one frame
    cnt = 0;
    while (!fifo_empty[eng] && cnt < WAIT_LIMIT)
    begin
      @(negedge clk);
      cnt++;
    end
    assert (fifo_empty[eng])
    else report_problem($sformatf("FIFO empty of engine %0d never rose", eng));
    discard[eng] = 1'b1;
    @(negedge clk);
    discard     = '0;
    cur_engine  = next_free(eng, busy);
    cnt         = 0;
    while (fifo_empty == '0 && cnt < WAIT_LIMIT)
    begin
      @(negedge clk);
      cnt++;
    end
    check_hex("o_dispatch_fifo_empty", fifo_empty, 64'(1) << cur_engine);
    empty_armed = fifo_empty[cur_engine];   // Watched until the next announce
  endtask

  // ------------------------------------------------------------
  // Cycle checks
  // ------------------------------------------------------------
  always @(posedge clk)
  begin
    if (!areset)
    begin
      assert ((avail & busy) == '0)
      else report_problem("a busy engine was offered a packet");
      assert ((avail & (avail - 1'b1)) == '0)
      else report_problem("a packet was offered to more than one engine");
      assert ((rd_valid & (rd_valid - 1'b1)) == '0)
      else report_problem("read data went to more than one engine");
      assert (!empty_armed || avail[cur_engine] || fifo_empty[cur_engine])
      else report_problem($sformatf("engine %0d FIFO empty fell before announce",
                                    cur_engine));
    end
  end

  initial
  begin
    #(RUN_CYCLES * CLK_PERIOD * 2);
    $display("Timeout: run did not finish within %0d cycles", 2 * RUN_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    void'($urandom(78));
    errors      = 0;
    checks      = 0;
    tests_run   = 0;
    tests_failed = 0;
    test_base   = 0;
    cur_engine  = 0;
    empty_armed = 1'b0;
    areset      = 1'b1;
    enable      = 1'b1;
    rx_data     = '0;
    rx_valid    = '0;
    rx_good     = 1'b0;
    rx_bad      = 1'b0;
    busy        = '0;
    discard     = '0;
    rd_start    = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    areset = 1'b0;
    @(negedge clk);

    check_hex("o_dispatch_packet_available", avail, 0);
    check_hex("o_dispatch_fifo_rd_valid", rd_valid, 0);
    check_hex("o_dispatch_fifo_empty", fifo_empty, 0);
    check_hex("o_dispatch_data_valid", data_valid, 0);
    end_test("reset values");

    repeat (2)
    begin
      send_frame(2 + $urandom % (MAX_WORDS - 1), 8, 1'b0, 1'b1);
      read_frame();
    end
    end_test("full frames to free engines");

    repeat (2)
    begin
      send_frame(2 + $urandom % (MAX_WORDS - 1), 1 + $urandom % 7, 1'b0, 1'b1);
      read_frame();
    end
    end_test("partial last word");

    send_frame(2 + $urandom % (MAX_WORDS - 1), 8, 1'b1, 1'b0);
    @(negedge clk);
    enable = 1'b0;
    send_frame(2 + $urandom % (MAX_WORDS - 1), 5, 1'b0, 1'b0);
    @(negedge clk);
    enable = 1'b1;
    expect_quiet(20);
    send_frame(2 + $urandom % (MAX_WORDS - 1), 3, 1'b0, 1'b1);
    read_frame();
    end_test("bad and disabled frames");

    repeat (2)
    begin
      @(negedge clk);
      busy = 1 << ((cur_engine + 1) % ENGINES);   // Next in turn is busy
      send_frame(2 + $urandom % (MAX_WORDS - 1), 1 + $urandom % 8, 1'b0, 1'b1);
      read_frame();
    end
    @(negedge clk);
    busy = '0;
    end_test("busy engines skipped");

    // Second frame waits for the read bank, third start is dropped
    send_frame(2 + $urandom % (MAX_WORDS - 1), 8, 1'b0, 1'b1);
    send_frame(2 + $urandom % (MAX_WORDS - 1), 6, 1'b0, 1'b1);
    send_frame(2 + $urandom % (MAX_WORDS - 1), 8, 1'b0, 1'b0);
    read_frame();
    read_frame();
    expect_quiet(20);
    end_test("ping-pong hand-over");

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- nts_dispatcher.f
+incdir+.
nts_rx_pkg.sv
nts_buf_pkg.sv
nts_rx_frontend.sv
nts_frame_writer.sv
nts_packet_buffer.sv
nts_fifo_reader.sv
nts_engine_select.sv
nts_dispatcher.sv
tb_nts_dispatcher.sv

//--- Bender.yml
package:
  name: nts_dispatcher

sources:
  - include_dirs:
      - .
    files:
      - nts_rx_pkg.sv
      - nts_buf_pkg.sv
      - nts_rx_frontend.sv
      - nts_frame_writer.sv
      - nts_packet_buffer.sv
      - nts_fifo_reader.sv
      - nts_engine_select.sv
      - nts_dispatcher.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_nts_dispatcher.sv
